/* build.f */
+incdir+testbench
logic/z8Pkg.sv
logic/z8Alu.sv
logic/z8Decode.sv
logic/z8RegFile.sv
logic/z8Sequencer.sv
logic/z8Execute.sv
logic/z8Core.sv
testbench/z8Tb.sv

/* logic/z8Alu.sv */
`timescale 1ns/1ps

module z8Alu
    import z8Pkg::*;
(
    input  aluModeT mode,
    input  logic [DataW-1:0] a,
    input  logic [DataW-1:0] b,
    input  logic [DataW-1:0] flagsIn,
    output logic [DataW-1:0] result,
    output logic [DataW-1:0] flagsOut
);

    logic lowCarry;
    logic highCarry;
    logic carryIn;
    logic [DataW-1:0] andOperand;

    always_comb begin
        flagsOut = flagsIn;
        result = a;
        lowCarry = 1'b0;
        highCarry = 1'b0;
        // adc and sbc have the low mode bit set
        carryIn = flagsIn[flagIdxC] & mode[0];
        andOperand = a;

        case (mode)
            aluDec: begin
                result = a - 8'd1;
                flagsOut[flagIdxV] = (a == 8'h80);
            end
            aluRlc: begin
                result = {a[6:0], flagsIn[flagIdxC]};
                flagsOut[flagIdxC] = a[7];
            end
            aluInc: begin
                result = a + 8'd1;
                flagsOut[flagIdxV] = (a == 8'h7F);
            end
            aluCom: begin
                result = ~a;
                flagsOut[flagIdxV] = 1'b0;
            end
            aluRl: begin
                result = {a[6:0], a[7]};
                flagsOut[flagIdxC] = a[7];
            end
            aluClr: begin
                result = '0;
            end
            aluRrc: begin
                result = {flagsIn[flagIdxC], a[7:1]};
                flagsOut[flagIdxC] = a[0];
            end
            aluSra: begin
                result = {a[7], a[7:1]};
                flagsOut[flagIdxC] = a[0];
            end
            aluRr: begin
                result = {a[0], a[7:1]};
                flagsOut[flagIdxC] = a[0];
            end
            aluSwap: begin
                result = {a[3:0], a[7:4]};
            end
            aluAdd, aluAdc: begin
                {lowCarry, result[3:0]} = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'b0, carryIn};
                {highCarry, result[7:4]} = {1'b0, a[7:4]} + {1'b0, b[7:4]} + {4'b0, lowCarry};
                flagsOut[flagIdxH] = lowCarry;
                flagsOut[flagIdxC] = highCarry;
                flagsOut[flagIdxD] = 1'b0;
                flagsOut[flagIdxV] = (a[7] == b[7]) & (a[7] != result[7]);
            end
            aluSub, aluSbc, aluCp: begin
                // Borrows come out of the top bit of each nibble step
                {lowCarry, result[3:0]} = {1'b0, a[3:0]} - {1'b0, b[3:0]} - {4'b0, carryIn};
                {highCarry, result[7:4]} = {1'b0, a[7:4]} - {1'b0, b[7:4]} - {4'b0, lowCarry};
                flagsOut[flagIdxH] = lowCarry;
                flagsOut[flagIdxC] = highCarry;
                flagsOut[flagIdxD] = 1'b1;
                flagsOut[flagIdxV] = (a[7] != b[7]) & (a[7] != result[7]);
            end
            aluOr: begin
                result = a | b;
                flagsOut[flagIdxV] = 1'b0;
            end
            aluAnd, aluTcm, aluTm: begin
                andOperand = mode[0] ? a : ~a;
                result = andOperand & b;
                flagsOut[flagIdxV] = 1'b0;
            end
            aluXor: begin
                result = a ^ b;
                flagsOut[flagIdxV] = 1'b0;
            end
            default: begin
                result = a;
            end
        endcase

        if (mode != aluClr && mode != aluModeLd) begin
            flagsOut[flagIdxZ] = (result == '0);
            flagsOut[flagIdxS] = result[7];
        end
    end

endmodule

/* logic/z8Core.sv */
`timescale 1ns/1ps

module z8Core
    import z8Pkg::*;
(
    input  logic clk,
    input  logic rstN,
    input  logic [DataW-1:0] memData,
    output logic [DataW-1:0] memAddr,
    output logic memStrobe,
    output regWriteT regWrite,
    output logic [DataW-1:0] flags
);

    fetchedT fetched;
    logic exec;
    logic [1:0] instrSize;
    logic takeBranch;
    logic [DataW-1:0] rdAddrA;
    logic [DataW-1:0] rdAddrB;
    logic [DataW-1:0] rdDataA;
    logic [DataW-1:0] rdDataB;
    aluModeT aluMode;
    logic [DataW-1:0] aluA;
    logic [DataW-1:0] aluB;
    logic [DataW-1:0] aluResult;
    logic [DataW-1:0] aluFlags;
    logic flagWrite;
    logic [DataW-1:0] flagsNew;
    logic srpLoad;
    logic [3:0] rpNew;

    z8Sequencer sequencer (
        .clk(clk),
        .rstN(rstN),
        .memData(memData),
        .memAddr(memAddr),
        .memStrobe(memStrobe),
        .instrSize(instrSize),
        .takeBranch(takeBranch),
        .fetched(fetched),
        .exec(exec)
    );

    z8Decode decode (
        .opcode(fetched.opcode),
        .flags(flags),
        .instrSize(instrSize),
        .takeBranch(takeBranch)
    );

    z8Execute execute (
        .clk(clk),
        .rstN(rstN),
        .exec(exec),
        .fetched(fetched),
        .rdAddrA(rdAddrA),
        .rdAddrB(rdAddrB),
        .rdDataA(rdDataA),
        .rdDataB(rdDataB),
        .flags(flags),
        .aluMode(aluMode),
        .aluA(aluA),
        .aluB(aluB),
        .aluResult(aluResult),
        .aluFlags(aluFlags),
        .regWrite(regWrite),
        .flagWrite(flagWrite),
        .flagsNew(flagsNew),
        .srpLoad(srpLoad),
        .rpNew(rpNew)
    );

    z8Alu alu (
        .mode(aluMode),
        .a(aluA),
        .b(aluB),
        .flagsIn(flags),
        .result(aluResult),
        .flagsOut(aluFlags)
    );

    // Register pointer is only needed inside the register file
    z8RegFile regFile (
        .clk(clk),
        .rstN(rstN),
        .rdAddrA(rdAddrA),
        .rdAddrB(rdAddrB),
        .rdDataA(rdDataA),
        .rdDataB(rdDataB),
        .regWrite(regWrite),
        .flagWrite(flagWrite),
        .flagsNew(flagsNew),
        .srpLoad(srpLoad),
        .rpNew(rpNew),
        .flags(flags),
        .rp()
    );

endmodule

/* logic/z8Decode.sv */
`timescale 1ns/1ps

module z8Decode
    import z8Pkg::*;
(
    input  instrByteU opcode,
    input  logic [DataW-1:0] flags,
    output logic [1:0] instrSize,
    output logic takeBranch
);

    logic lessThan;
    logic condition;

    assign lessThan = flags[flagIdxS] ^ flags[flagIdxV];

    // Length from the low nibble alone
    always_comb begin
        if (opcode.nib.lo[3:1] == 3'b111) begin
            instrSize = 2'd1;
        end else if (opcode.nib.lo[3:2] == 2'b01 || opcode.nib.lo == 4'hD) begin
            instrSize = 2'd3;
        end else begin
            instrSize = 2'd2;
        end
    end

    // f, lt, le, ule, ov, mi, z, c
    always_comb begin
        case (opcode.nib.hi[2:0])
            3'd0: condition = 1'b0;
            3'd1: condition = lessThan;
            3'd2: condition = lessThan | flags[flagIdxZ];
            3'd3: condition = flags[flagIdxC] | flags[flagIdxZ];
            3'd4: condition = flags[flagIdxV];
            3'd5: condition = flags[flagIdxS];
            3'd6: condition = flags[flagIdxZ];
            default: condition = flags[flagIdxC];
        endcase
    end

    // Upper half of the codes is the negated set, so 8 means always
    assign takeBranch = condition ^ opcode.nib.hi[3];

endmodule

/* logic/z8Execute.sv */
`timescale 1ns/1ps

module z8Execute
    import z8Pkg::*;
(
    input  logic clk,
    input  logic rstN,
    input  logic exec,
    input  fetchedT fetched,
    output logic [DataW-1:0] rdAddrA,
    output logic [DataW-1:0] rdAddrB,
    input  logic [DataW-1:0] rdDataA,
    input  logic [DataW-1:0] rdDataB,
    input  logic [DataW-1:0] flags,
    output aluModeT aluMode,
    output logic [DataW-1:0] aluA,
    output logic [DataW-1:0] aluB,
    input  logic [DataW-1:0] aluResult,
    input  logic [DataW-1:0] aluFlags,
    output regWriteT regWrite,
    output logic flagWrite,
    output logic [DataW-1:0] flagsNew,
    output logic srpLoad,
    output logic [3:0] rpNew
);

    logic [3:0] opHi;
    logic [3:0] opLo;
    logic singleOpValid;
    logic twoOpValid;
    logic writesBack;
    logic issueWrite;
    logic issueFlags;
    aluModeT nextMode;
    logic [DataW-1:0] nextA;
    logic [DataW-1:0] nextB;
    logic [DataW-1:0] nextDst;
    logic [DataW-1:0] dstAddr;
    logic pendWrite;
    logic pendFlags;
    logic carryOp;

    assign opHi = fetched.opcode.nib.hi;
    assign opLo = fetched.opcode.nib.lo;

    assign singleOpValid = !(opHi inside {4'h3, 4'h4, 4'h5, 4'h7, 4'h8, 4'hA});
    assign twoOpValid = !(opHi inside {4'h8, 4'h9, 4'hC, 4'hD, 4'hE, 4'hF});
    // add, adc, sub, sbc, or, and, xor
    assign writesBack = (opHi[3:2] == 2'b00) | (opHi[3:1] == 3'b010) | (opHi == 4'hB);

    assign rdAddrB = {workingPrefix, fetched.second.nib.lo};

    always_comb begin
        rdAddrA = fetched.second.whole;
        nextMode = aluModeLd;
        nextA = rdDataA;
        nextB = rdDataB;
        nextDst = fetched.second.whole;
        issueWrite = 1'b0;
        issueFlags = 1'b0;

        case (opLo)
            4'h0: begin
                if (singleOpValid) begin
                    nextMode = {1'b0, opHi};
                    issueWrite = 1'b1;
                    issueFlags = 1'b1;
                end
            end
            4'h2, 4'h6: begin
                if (twoOpValid) begin
                    nextMode = {1'b1, opHi};
                    issueWrite = writesBack;
                    issueFlags = 1'b1;
                    if (opLo == 4'h2) begin
                        rdAddrA = {workingPrefix, fetched.second.nib.hi};
                        nextDst = {workingPrefix, fetched.second.nib.hi};
                    end else begin
                        nextB = fetched.third.whole;
                    end
                end
            end
            4'h8: begin
                nextDst = {workingPrefix, opHi};
                issueWrite = 1'b1;
            end
            4'hC: begin
                nextDst = {workingPrefix, opHi};
                nextA = fetched.second.whole;
                issueWrite = 1'b1;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pendWrite <= 1'b0;
            pendFlags <= 1'b0;
        end else begin
            pendWrite <= exec & issueWrite;
            pendFlags <= exec & issueFlags;
        end
    end

    always_ff @(posedge clk) begin
        if (exec) begin
            aluMode <= nextMode;
            aluA <= nextA;
            aluB <= nextB;
            dstAddr <= nextDst;
        end
    end

    // Result goes out the cycle after exec
    assign regWrite = '{en: pendWrite, addr: dstAddr, data: aluResult};

    // rcf, scf, ccf act right away in exec
    assign carryOp = exec && opLo == 4'hF && (opHi inside {4'hC, 4'hD, 4'hE});
    assign flagWrite = pendFlags | carryOp;

    always_comb begin
        flagsNew = aluFlags;
        if (carryOp) begin
            flagsNew = flags;
            flagsNew[flagIdxC] = (opHi == 4'hE) ? ~flags[flagIdxC] : opHi[0];
        end
    end

    // Only opcode 31 is srp, the rest of that column is unused
    assign srpLoad = exec && opHi == 4'h3 && opLo == 4'h1;
    assign rpNew = fetched.second.nib.hi;

endmodule

/* logic/z8Pkg.sv */
package z8Pkg;

    localparam int DataW = 8;

    // Bit positions inside the flags register
    localparam int flagIdxC = 7;
    localparam int flagIdxZ = 6;
    localparam int flagIdxS = 5;
    localparam int flagIdxV = 4;
    localparam int flagIdxD = 3;
    localparam int flagIdxH = 2;

    // Top bit picks the group, low nibble is the opcode high nibble
    typedef logic [4:0] aluModeT;

    localparam aluModeT aluDec  = 5'h00;
    localparam aluModeT aluRlc  = 5'h01;
    localparam aluModeT aluInc  = 5'h02;
    localparam aluModeT aluCom  = 5'h06;
    localparam aluModeT aluRl   = 5'h09;
    localparam aluModeT aluClr  = 5'h0B;
    localparam aluModeT aluRrc  = 5'h0C;
    localparam aluModeT aluSra  = 5'h0D;
    localparam aluModeT aluRr   = 5'h0E;
    localparam aluModeT aluSwap = 5'h0F;
    localparam aluModeT aluAdd  = 5'h10;
    localparam aluModeT aluAdc  = 5'h11;
    localparam aluModeT aluSub  = 5'h12;
    localparam aluModeT aluSbc  = 5'h13;
    localparam aluModeT aluOr   = 5'h14;
    localparam aluModeT aluAnd  = 5'h15;
    localparam aluModeT aluTcm  = 5'h16;
    localparam aluModeT aluTm   = 5'h17;
    localparam aluModeT aluCp   = 5'h1A;
    localparam aluModeT aluXor  = 5'h1B;
    // Unused two-operand slot, operand a passes straight through
    localparam aluModeT aluModeLd = 5'h1F;

    localparam logic [DataW-1:0] regFlags = 8'hFC;
    localparam logic [DataW-1:0] regRp    = 8'hFD;
    localparam logic [3:0] workingPrefix  = 4'hE;

    typedef enum logic [2:0] {
        seqFetch,
        seqRead1,
        seqWait2,
        seqRead2,
        seqWait3,
        seqRead3,
        seqExec
    } seqStateT;

    typedef struct packed {
        logic [3:0] hi;
        logic [3:0] lo;
    } nibblePairT;

    // Instruction byte, whole or split into nibbles
    typedef union packed {
        logic [DataW-1:0] whole;
        nibblePairT nib;
    } instrByteU;

    typedef struct packed {
        instrByteU opcode;
        instrByteU second;
        instrByteU third;
    } fetchedT;

    typedef struct packed {
        logic en;
        logic [DataW-1:0] addr;
        logic [DataW-1:0] data;
    } regWriteT;

endpackage

/* logic/z8RegFile.sv */
`timescale 1ns/1ps

module z8RegFile
    import z8Pkg::*;
(
    input  logic clk,
    input  logic rstN,
    input  logic [DataW-1:0] rdAddrA,
    input  logic [DataW-1:0] rdAddrB,
    output logic [DataW-1:0] rdDataA,
    output logic [DataW-1:0] rdDataB,
    input  regWriteT regWrite,
    input  logic flagWrite,
    input  logic [DataW-1:0] flagsNew,
    input  logic srpLoad,
    input  logic [3:0] rpNew,
    output logic [DataW-1:0] flags,
    output logic [3:0] rp
);

    logic [DataW-1:0] regArray [0:127];
    logic [DataW-1:0] flagsQ;
    logic [3:0] rpQ;
    logic [DataW-1:0] wrAddr;

    // Working registers sit in the bank chosen by rp
    function automatic logic [DataW-1:0] mapAddr(input logic [DataW-1:0] addr,
                                                 input logic [3:0] pointer);
        if (addr[7:4] == workingPrefix) begin
            return {pointer, addr[3:0]};
        end
        return addr;
    endfunction

    function automatic logic [DataW-1:0] readReg(input logic [DataW-1:0] addr);
        if (!addr[7]) begin
            return regArray[addr[6:0]];
        end else if (addr == regFlags) begin
            return flagsQ;
        end else if (addr == regRp) begin
            return {rpQ, 4'h0};
        end
        return '0;
    endfunction

    assign rdDataA = readReg(mapAddr(rdAddrA, rpQ));
    assign rdDataB = readReg(mapAddr(rdAddrB, rpQ));
    assign wrAddr = mapAddr(regWrite.addr, rpQ);

    always_ff @(posedge clk) begin
        if (regWrite.en && !wrAddr[7]) begin
            regArray[wrAddr[6:0]] <= regWrite.data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            flagsQ <= '0;
            rpQ <= '0;
        end else begin
            if (flagWrite) begin
                flagsQ <= flagsNew;
            end
            if (srpLoad) begin
                rpQ <= rpNew;
            end
            // Explicit register writes land last and take priority
            if (regWrite.en && wrAddr == regFlags) begin
                flagsQ <= regWrite.data;
            end
            if (regWrite.en && wrAddr == regRp) begin
                rpQ <= regWrite.data[7:4];
            end
        end
    end

    assign flags = flagsQ;
    assign rp = rpQ;

endmodule

/* logic/z8Sequencer.sv */
`timescale 1ns/1ps

module z8Sequencer
    import z8Pkg::*;
(
    input  logic clk,
    input  logic rstN,
    input  logic [DataW-1:0] memData,
    output logic [DataW-1:0] memAddr,
    output logic memStrobe,
    input  logic [1:0] instrSize,
    input  logic takeBranch,
    output fetchedT fetched,
    output logic exec
);

    seqStateT state;
    seqStateT nextState;
    logic [DataW-1:0] pc;

    always_comb begin
        case (state)
            seqFetch: nextState = seqRead1;
            seqRead1: nextState = seqWait2;
            seqWait2: nextState = (instrSize == 2'd1) ? seqExec : seqRead2;
            seqRead2: nextState = (instrSize == 2'd2) ? seqExec : seqWait3;
            seqWait3: nextState = seqRead3;
            seqRead3: nextState = seqExec;
            default:  nextState = seqFetch;
        endcase
    end

    // Data comes back the cycle after the strobe
    assign memStrobe = (state == seqFetch)
                     | (state == seqWait2 && instrSize != 2'd1)
                     | (state == seqWait3);
    assign memAddr = pc;
    assign exec = (state == seqExec);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= seqFetch;
            pc <= '0;
        end else begin
            state <= nextState;
            case (state)
                seqRead1, seqRead2, seqRead3: begin
                    pc <= pc + 8'd1;
                end
                seqExec: begin
                    // pc already points past the instruction here
                    if (takeBranch && fetched.opcode.nib.lo == 4'hB) begin
                        pc <= pc + fetched.second.whole;
                    end else if (takeBranch && fetched.opcode.nib.lo == 4'hD) begin
                        pc <= fetched.third.whole;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == seqRead1) begin
            fetched.opcode.whole <= memData;
        end
        if (state == seqRead2) begin
            fetched.second.whole <= memData;
        end
        if (state == seqRead3) begin
            fetched.third.whole <= memData;
        end
    end

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module z8Tb -f build.f \
    -Mdir obj_dir -o z8Sim
./obj_dir/z8Sim

/* testbench/z8TbModel.svh */
`ifndef Z8_TB_MODEL_SVH
`define Z8_TB_MODEL_SVH

localparam int cBit = 7;
localparam int zBit = 6;
localparam int sBit = 5;
localparam int vBit = 4;
localparam int dBit = 3;
localparam int hBit = 2;

// Opcode high nibbles of the kept ALU groups
localparam logic [39:0] singleHiList = 40'h0_1_2_6_9_B_C_D_E_F;
localparam logic [39:0] pairHiList = 40'h0_1_2_3_4_5_6_7_A_B;
// Carry ops, nop and some dropped opcodes
localparam logic [79:0] otherOpList = 80'hCF_DF_EF_FF_21_80_A0_8F_0E_2A;

typedef struct packed {
    logic [31:0] cycle;
    logic [7:0] addr;
    logic [7:0] data;
} expectT;

logic [15:0] lfsrState = 16'd11116;
logic [7:0] progMem [0:255];
logic [7:0] progEnd;
int buildPc;
expectT strobeQ[$];
expectT writeQ[$];
expectT flagsQ[$];

function automatic expectT makeEvent(input logic [31:0] cycle, input logic [7:0] addr,
                                     input logic [7:0] data);
    expectT e;
    e.cycle = cycle;
    e.addr = addr;
    e.data = data;
    return e;
endfunction

// Galois LFSR, one step per bit handed out
function automatic logic [7:0] randBits(input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        if (lfsrState[0]) begin
            lfsrState = (lfsrState >> 1) ^ 16'hB400;
        end else begin
            lfsrState = lfsrState >> 1;
        end
        v = {v[6:0], lfsrState[0]};
    end
    return v;
endfunction

function automatic logic [1:0] sizeOf(input logic [7:0] op);
    if (op[3:0] == 4'hE || op[3:0] == 4'hF) begin
        return 2'd1;
    end
    if (op[3:0] inside {[4'h4:4'h7], 4'hD}) begin
        return 2'd3;
    end
    return 2'd2;
endfunction

function automatic logic [7:0] mapReg(input logic [7:0] addr, input logic [3:0] rp);
    return (addr[7:4] == 4'hE) ? {rp, addr[3:0]} : addr;
endfunction

// Registers 00 to 1F, directly or through the working bank
function automatic logic [7:0] pickReg();
    logic [7:0] r;
    r = randBits(5);
    if (randBits(1) != 0) begin
        return {4'hE, r[3:0]};
    end
    return r;
endfunction

function automatic logic condRef(input logic [3:0] cc, input logic [7:0] f);
    logic lt;
    logic base;
    lt = f[sBit] ^ f[vBit];
    case (cc[2:0])
        3'd0: base = 1'b0;
        3'd1: base = lt;
        3'd2: base = lt | f[zBit];
        3'd3: base = f[cBit] | f[zBit];
        3'd4: base = f[vBit];
        3'd5: base = f[sBit];
        3'd6: base = f[zBit];
        default: base = f[cBit];
    endcase
    return base ^ cc[3];
endfunction

task automatic singleRef(input logic [3:0] hi, input logic [7:0] a, input logic [7:0] fIn,
                         output logic [7:0] res, output logic [7:0] fOut);
    fOut = fIn;
    case (hi)
        4'h0: begin
            res = a - 8'd1;
            fOut[vBit] = (a == 8'h80);
        end
        4'h1: begin
            res = {a[6:0], fIn[cBit]};
            fOut[cBit] = a[7];
        end
        4'h2: begin
            res = a + 8'd1;
            fOut[vBit] = (a == 8'h7F);
        end
        4'h6: begin
            res = ~a;
            fOut[vBit] = 1'b0;
        end
        4'h9: begin
            res = {a[6:0], a[7]};
            fOut[cBit] = a[7];
        end
        4'hB: res = 8'h00;
        4'hC: begin
            res = {fIn[cBit], a[7:1]};
            fOut[cBit] = a[0];
        end
        4'hD: begin
            res = {a[7], a[7:1]};
            fOut[cBit] = a[0];
        end
        4'hE: begin
            res = {a[0], a[7:1]};
            fOut[cBit] = a[0];
        end
        default: res = {a[3:0], a[7:4]};
    endcase
    // clr keeps Z and S
    if (hi != 4'hB) begin
        fOut[zBit] = (res == 8'h00);
        fOut[sBit] = res[7];
    end
endtask

task automatic pairRef(input logic [3:0] hi, input logic [7:0] a, input logic [7:0] b,
                       input logic [7:0] fIn, output logic [7:0] res, output logic [7:0] fOut);
    logic cin;
    logic [8:0] wide;
    logic [4:0] low;
    fOut = fIn;
    cin = (hi == 4'h1 || hi == 4'h3) ? fIn[cBit] : 1'b0;
    case (hi)
        4'h0, 4'h1: begin
            wide = {1'b0, a} + {1'b0, b} + {8'b0, cin};
            low = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'b0, cin};
            res = wide[7:0];
            fOut[cBit] = wide[8];
            fOut[hBit] = low[4];
            fOut[dBit] = 1'b0;
            fOut[vBit] = (a[7] == b[7]) && (res[7] != a[7]);
        end
        4'h2, 4'h3, 4'hA: begin
            // Bit 8 of the wide difference is the borrow
            wide = {1'b0, a} - {1'b0, b} - {8'b0, cin};
            low = {1'b0, a[3:0]} - {1'b0, b[3:0]} - {4'b0, cin};
            res = wide[7:0];
            fOut[cBit] = wide[8];
            fOut[hBit] = low[4];
            fOut[dBit] = 1'b1;
            fOut[vBit] = (a[7] != b[7]) && (res[7] != a[7]);
        end
        default: begin
            case (hi)
                4'h4: res = a | b;
                4'h5: res = a & b;
                4'h6: res = ~a & b;
                4'h7: res = a & b;
                default: res = a ^ b;
            endcase
            fOut[vBit] = 1'b0;
        end
    endcase
    fOut[zBit] = (res == 8'h00);
    fOut[sBit] = res[7];
endtask

task automatic putByte(input logic [7:0] b);
    progMem[buildPc] = b;
    buildPc++;
endtask

task automatic emitPlain(input int kind);
    logic [7:0] op;
    int idx;
    case (kind)
        0: begin
            op = randBits(4);
            putByte({op[3:0], 4'hC});
            putByte(randBits(8));
        end
        1: begin
            op = randBits(4);
            putByte({op[3:0], 4'h8});
            putByte(pickReg());
        end
        2: begin
            idx = randBits(4) % 10;
            putByte({singleHiList[idx*4 +: 4], 4'h0});
            putByte(pickReg());
        end
        3: begin
            idx = randBits(4) % 10;
            putByte({pairHiList[idx*4 +: 4], 4'h2});
            putByte(randBits(8));
        end
        4: begin
            idx = randBits(4) % 10;
            putByte({pairHiList[idx*4 +: 4], 4'h6});
            putByte(pickReg());
            putByte(randBits(8));
        end
        5: begin
            op = randBits(1);
            putByte(8'h31);
            putByte({3'b000, op[0], 4'h0});
        end
        default: begin
            idx = randBits(4) % 10;
            op = otherOpList[idx*8 +: 8];
            putByte(op);
            for (int i = 1; i < sizeOf(op); i++) begin
                putByte(randBits(8));
            end
        end
    endcase
endtask

// Forward jump over exactly one instruction, so both paths meet again
task automatic emitJump();
    logic [7:0] cond;
    logic [7:0] isJp;
    int at;
    int after;
    cond = randBits(4);
    isJp = randBits(1);
    at = buildPc;
    putByte({cond[3:0], isJp[0] ? 4'hD : 4'hB});
    putByte(randBits(8));
    if (isJp[0]) begin
        putByte(8'h00);
    end
    after = buildPc;
    emitPlain(randBits(3) % 7);
    if (isJp[0]) begin
        progMem[at + 2] = buildPc[7:0];
    end else begin
        progMem[at + 1] = 8'(buildPc - after);
    end
endtask

task automatic buildProgram();
    for (int i = 0; i < 256; i++) begin
        progMem[i] = i[7:0] ^ 8'h5A;
    end
    buildPc = 0;
    // Seed registers 00 to 1F through both working banks
    for (int bank = 0; bank < 2; bank++) begin
        putByte(8'h31);
        putByte({3'b000, bank[0], 4'h0});
        for (int n = 0; n < 16; n++) begin
            putByte({n[3:0], 4'hC});
            putByte(randBits(8));
        end
    end
    putByte(8'hDF);
    putByte(8'hEF);
    putByte(8'hCF);
    while (buildPc < 224) begin
        if (randBits(3) == 8'd7) begin
            emitJump();
        end else begin
            emitPlain(randBits(3) % 7);
        end
    end
    progEnd = buildPc[7:0];
    progMem[buildPc] = 8'hFF;
endtask

task automatic runModel();
    logic [7:0] regs [0:255];
    logic [7:0] pc;
    logic [7:0] op;
    logic [7:0] b2;
    logic [7:0] b3;
    logic [7:0] nextPc;
    logic [7:0] dst;
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] res;
    logic [7:0] fl;
    logic [3:0] rp;
    logic [1:0] sz;
    logic [31:0] t;
    logic [31:0] tNext;
    pc = 8'h00;
    fl = 8'h00;
    rp = 4'h0;
    t = 0;
    while (pc != progEnd) begin
        op = progMem[pc];
        b2 = progMem[pc + 8'd1];
        b3 = progMem[pc + 8'd2];
        sz = sizeOf(op);
        strobeQ.push_back(makeEvent(t, pc, 8'h00));
        if (sz != 2'd1) begin
            strobeQ.push_back(makeEvent(t + 2, pc + 8'd1, 8'h00));
        end
        if (sz == 2'd3) begin
            strobeQ.push_back(makeEvent(t + 4, pc + 8'd2, 8'h00));
        end
        flagsQ.push_back(makeEvent(t + 1, 8'h00, fl));
        tNext = t + ((sz == 2'd1) ? 4 : ((sz == 2'd2) ? 5 : 7));
        nextPc = pc + {6'b0, sz};
        case (op[3:0])
            4'h0: begin
                if (op[7:4] inside {4'h0, 4'h1, 4'h2, 4'h6, 4'h9, [4'hB:4'hF]}) begin
                    singleRef(op[7:4], regs[mapReg(b2, rp)], fl, res, fl);
                    regs[mapReg(b2, rp)] = res;
                    writeQ.push_back(makeEvent(tNext, b2, res));
                end
            end
            4'h2, 4'h6: begin
                if (op[7:4] inside {[4'h0:4'h7], 4'hA, 4'hB}) begin
                    if (op[3:0] == 4'h2) begin
                        dst = {4'hE, b2[7:4]};
                        b = regs[mapReg({4'hE, b2[3:0]}, rp)];
                    end else begin
                        dst = b2;
                        b = b3;
                    end
                    a = regs[mapReg(dst, rp)];
                    pairRef(op[7:4], a, b, fl, res, fl);
                    if (op[7:4] <= 4'h5 || op[7:4] == 4'hB) begin
                        regs[mapReg(dst, rp)] = res;
                        writeQ.push_back(makeEvent(tNext, dst, res));
                    end
                end
            end
            4'h8, 4'hC: begin
                dst = {4'hE, op[7:4]};
                res = (op[3:0] == 4'h8) ? regs[mapReg(b2, rp)] : b2;
                regs[mapReg(dst, rp)] = res;
                writeQ.push_back(makeEvent(tNext, dst, res));
            end
            4'h1: begin
                if (op[7:4] == 4'h3) begin
                    rp = b2[7:4];
                end
            end
            4'hB: begin
                if (condRef(op[7:4], fl)) begin
                    nextPc = nextPc + b2;
                end
            end
            4'hD: begin
                if (condRef(op[7:4], fl)) begin
                    nextPc = b3;
                end
            end
            4'hF: begin
                // rcf, scf, ccf
                case (op[7:4])
                    4'hC: fl[cBit] = 1'b0;
                    4'hD: fl[cBit] = 1'b1;
                    4'hE: fl[cBit] = ~fl[cBit];
                    default: begin
                    end
                endcase
            end
            default: begin
            end
        endcase
        pc = nextPc;
        t = tNext;
    end
    // Fetch of the end address closes the program
    strobeQ.push_back(makeEvent(t, pc, 8'h00));
    flagsQ.push_back(makeEvent(t + 1, 8'h00, fl));
endtask

`endif

/* testbench/z8Tb.sv */
`timescale 1ns/1ps

module z8Tb
    import z8Pkg::*;
();

    logic clk;
    logic rstN;
    logic [DataW-1:0] memData;
    logic [DataW-1:0] memAddr;
    logic memStrobe;
    regWriteT regWrite;
    logic [DataW-1:0] flags;
    logic [31:0] cycle = '0;

    `include "z8TbModel.svh"

    z8Core UUT (
        .clk(clk),
        .rstN(rstN),
        .memData(memData),
        .memAddr(memAddr),
        .memStrobe(memStrobe),
        .regWrite(regWrite),
        .flags(flags)
    );

    task automatic stopRun(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (expected == actual) else begin
            stopRun($sformatf("ERROR at %0t ns: %s expected %0h, got %0h",
                              $time, name, expected, actual));
        end
    endtask

    function automatic int pending();
        return strobeQ.size() + writeQ.size() + flagsQ.size();
    endfunction

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Cycle 0 is the first fetch after reset
    always @(posedge clk) begin
        if (rstN) begin
            cycle <= cycle + 1;
        end
    end

    // Memory answers one cycle after the strobe
    always @(posedge clk) begin
        if (memStrobe) begin
            memData <= progMem[memAddr];
        end
    end

    always @(negedge clk) begin
        expectT e;
        if (rstN && pending() != 0) begin
            if (memStrobe) begin
                assert (strobeQ.size() != 0) else stopRun("Fetch strobe after the last expected one");
                e = strobeQ.pop_front();
                checkValue("memStrobe cycle", e.cycle, cycle);
                checkValue("memAddr", {24'b0, e.addr}, {24'b0, memAddr});
            end else if (strobeQ.size() != 0) begin
                assert (strobeQ[0].cycle > cycle) else stopRun("An expected fetch strobe is missing");
            end
            if (regWrite.en) begin
                assert (writeQ.size() != 0) else stopRun("Register write that the program never issues");
                e = writeQ.pop_front();
                checkValue("regWrite cycle", e.cycle, cycle);
                checkValue("regWrite.addr", {24'b0, e.addr}, {24'b0, regWrite.addr});
                checkValue("regWrite.data", {24'b0, e.data}, {24'b0, regWrite.data});
            end else if (writeQ.size() != 0) begin
                assert (writeQ[0].cycle > cycle) else stopRun("An expected register write is missing");
            end
            if (flagsQ.size() != 0 && flagsQ[0].cycle == cycle) begin
                e = flagsQ.pop_front();
                checkValue("flags", {24'b0, e.data}, {24'b0, flags});
            end
        end
    end

    initial begin
        #1;
        #((16 + int'(progEnd) * 7) * 20 * 2);
        stopRun("Watchdog expired before the program finished");
    end

    initial begin
        rstN = 1'b0;
        memData = '0;
        buildProgram();
        runModel();
        repeat (16) @(posedge clk);
        rstN <= 1'b1;
        while (pending() != 0) begin
            @(negedge clk);
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule
